// File: cache_consts.svh
/*
 * Cache storage geometry
 * Address split, block size, associativity and LRU history widths
 * shared by the package and every storage module
 */

`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// ==============================
// Address split
// ==============================
// Byte address into the block store
`define CACHE_ADDR_W    32
// One block per entry
`define CACHE_DATA_W    64
// Byte offset inside a block
`define CACHE_OFFSET_W  3
// Tag is what is left above index and offset
`define CACHE_TAG_W     26

// ==============================
// Organization
// ==============================
`define CACHE_SETS      8
`define CACHE_IDX_W     3
`define CACHE_WAYS      4
`define CACHE_WAY_W     2
// One history bit per way pair, 4*3/2
`define CACHE_HIST_W    6

`endif

// File: cache_pkg.sv
/*
 * Cache storage types
 * Command encoding and the packed records passed between the
 * request control, lookup, way array and top level
 */

`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

    // Commands from the cache controller
    typedef enum logic [2:0] {
        REQ_NONE       = 3'd0,
        REQ_LOAD       = 3'd1,
        REQ_STORE      = 3'd2,
        REQ_LOAD_MISS  = 3'd3,
        REQ_STORE_MISS = 3'd4
    } req_cmd_e;

    // One command per cycle
    typedef struct packed {
        req_cmd_e                   cmd;
        logic [`CACHE_ADDR_W-1:0]   addr;
        logic [`CACHE_DATA_W-1:0]   data_in;
    } cache_req_t;

    // Same-cycle answer, eviction fields only on a full-set fill
    typedef struct packed {
        logic                       hit;
        logic [`CACHE_DATA_W-1:0]   data_out;
        logic                       evict_valid;
        logic                       evict_dirty;
        logic [`CACHE_ADDR_W-1:0]   evict_addr;
        logic [`CACHE_DATA_W-1:0]   evict_data;
    } cache_rsp_t;

    // Stored state of one way
    typedef struct packed {
        logic                       valid;
        logic                       dirty;
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_DATA_W-1:0]   data;
    } cache_entry_t;

    // All ways of one set, way 0 in the low bits
    typedef cache_entry_t [`CACHE_WAYS-1:0] cache_set_t;

    // Single-entry write into the array
    typedef struct packed {
        logic                       en;
        logic [`CACHE_IDX_W-1:0]    set;
        logic [`CACHE_WAY_W-1:0]    way;
        cache_entry_t               entry;
    } way_write_t;

endpackage

`default_nettype wire

// File: cache_way_array.sv
/*
 * Cache way array
 * Holds valid, dirty, tag and data of every way of every set.
 * Whole-set combinational read, one-entry registered write
 */

`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module cache_way_array (
    input  wire logic                       clk_i,
    input  wire logic                       rst_i,
    // Set addressed by the current command
    input  wire logic [`CACHE_IDX_W-1:0]    rd_set_i,
    // Entry update from request control
    input  wire cache_pkg::way_write_t      wr_i,
    output      cache_pkg::cache_set_t      set_entries_o
);

    // ==============================
    // Storage
    // ==============================
    // One packed set per index
    cache_pkg::cache_set_t entries_q [`CACHE_SETS];

    // Clear everything on reset so all ways start invalid and clean
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                entries_q[s] <= '0;
            end
        end else if (wr_i.en) begin
            // Only the selected way changes
            entries_q[wr_i.set][wr_i.way] <= wr_i.entry;
        end
    end

    // ==============================
    // Read port
    // ==============================
    // Combinational, same cycle as the command
    assign set_entries_o = entries_q[rd_set_i];

    // ==============================
    // Checks
    // ==============================
    // Request control only writes on hits and fills,
    // both of which leave a live block behind
    a_wr_entry_valid : assert property (
        @(posedge clk_i) disable iff (rst_i)
        wr_i.en |-> wr_i.entry.valid
    ) else $error("way array write with invalid entry, set %0d way %0d",
                  wr_i.set, wr_i.way);

endmodule

`default_nettype wire

// File: cache_way_lookup.sv
/*
 * Cache way lookup
 * Tag match across the ways of the addressed set,
 * plus search for the lowest-numbered invalid way
 */

`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module cache_way_lookup (
    input  wire cache_pkg::cache_set_t      set_entries_i,
    input  wire logic [`CACHE_TAG_W-1:0]    tag_i,
    output      logic                       hit_o,
    output      logic [`CACHE_WAY_W-1:0]    hit_way_o,
    output      logic                       empty_valid_o,
    output      logic [`CACHE_WAY_W-1:0]    empty_way_o
);

    // Per-way match flags
    logic [`CACHE_WAYS-1:0] hit_vec;

    // ==============================
    // Tag compare
    // ==============================
    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_vec[w] = set_entries_i[w].valid && (set_entries_i[w].tag == tag_i);
            // Encoder, a single match is expected
            if (hit_vec[w]) begin
                hit_way_o = w[`CACHE_WAY_W-1:0];
            end
        end
        hit_o = |hit_vec;
    end

    // ==============================
    // Empty way search
    // ==============================
    // Scan downward so the lowest invalid way wins
    always_comb begin
        empty_valid_o = 1'b0;
        empty_way_o   = '0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!set_entries_i[w].valid) begin
                empty_valid_o = 1'b1;
                empty_way_o   = w[`CACHE_WAY_W-1:0];
            end
        end
    end

    // Fills reuse a present block, so a tag never lands in two ways
    always_comb begin
        a_single_hit : assert final ($onehot0(hit_vec))
            else $error("multiple ways match tag %h, hits %b", tag_i, hit_vec);
    end

endmodule

`default_nettype wire

// File: cache_lru_matrix.sv
/*
 * LRU use-history matrices
 * One bit per way pair and set. A touch makes a way the newest
 * of its set. The victim is the way older than all others
 */

`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module cache_lru_matrix (
    input  wire logic                       clk_i,
    input  wire logic                       rst_i,
    input  wire logic [`CACHE_IDX_W-1:0]    set_i,
    input  wire logic                       touch_i,
    input  wire logic [`CACHE_WAY_W-1:0]    touch_way_i,
    output      logic [`CACHE_WAY_W-1:0]    victim_way_o
);

    // Bit (lo,hi) set means way lo was used after way hi
    logic [`CACHE_HIST_W-1:0] hist_q [`CACHE_SETS];
    // Updated history row of the addressed set
    logic [`CACHE_HIST_W-1:0] hist_row_d;
    // One-hot oldest way of every set
    logic [`CACHE_WAYS-1:0]   victim_hot [`CACHE_SETS];

    // Pair order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
    function automatic int pair_idx(input int lo, input int hi);
        return lo * (2 * `CACHE_WAYS - lo - 1) / 2 + (hi - lo - 1);
    endfunction

    // ==============================
    // Touch update
    // ==============================
    always_comb begin
        hist_row_d = hist_q[set_i];
        for (int o = 0; o < `CACHE_WAYS; o++) begin
            // Lower partner loses its claim, higher partner becomes older
            if (o < int'(touch_way_i)) begin
                hist_row_d[pair_idx(o, int'(touch_way_i))] = 1'b0;
            end else if (o > int'(touch_way_i)) begin
                hist_row_d[pair_idx(int'(touch_way_i), o)] = 1'b1;
            end
        end
    end

    // Zero history orders way 0 oldest through way 3 newest
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                hist_q[s] <= '0;
            end
        end else if (touch_i) begin
            hist_q[set_i] <= hist_row_d;
        end
    end

    // ==============================
    // Victim select
    // ==============================
    always_comb begin
        for (int s = 0; s < `CACHE_SETS; s++) begin
            for (int v = 0; v < `CACHE_WAYS; v++) begin
                victim_hot[s][v] = 1'b1;
                for (int o = 0; o < `CACHE_WAYS; o++) begin
                    // Victim needs every other way newer than itself
                    if (o < v && !hist_q[s][pair_idx(o, v)]) begin
                        victim_hot[s][v] = 1'b0;
                    end
                    if (o > v && hist_q[s][pair_idx(v, o)]) begin
                        victim_hot[s][v] = 1'b0;
                    end
                end
            end
        end
        victim_way_o = '0;
        for (int v = 0; v < `CACHE_WAYS; v++) begin
            if (victim_hot[set_i][v]) begin
                victim_way_o = v[`CACHE_WAY_W-1:0];
            end
        end
    end

    // Touches must keep each matrix a strict total order
    for (genvar s = 0; s < `CACHE_SETS; s++) begin : g_chk
        a_one_victim : assert property (
            @(posedge clk_i) disable iff (rst_i) $onehot(victim_hot[s])
        ) else $error("set %0d has victim vector %b", s, victim_hot[s]);
    end

endmodule

`default_nettype wire

// File: cache_req_ctrl.sv
/*
 * Cache request control
 * Decodes the command, splits the address, builds the entry write
 * and LRU touch, and forms the hit and eviction response
 */

`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module cache_req_ctrl (
    input  wire cache_pkg::cache_req_t      req_i,
    input  wire cache_pkg::cache_set_t      set_entries_i,
    // Lookup results for the addressed set
    input  wire logic                       hit_i,
    input  wire logic [`CACHE_WAY_W-1:0]    hit_way_i,
    input  wire logic                       empty_valid_i,
    input  wire logic [`CACHE_WAY_W-1:0]    empty_way_i,
    // Oldest way of the addressed set
    input  wire logic [`CACHE_WAY_W-1:0]    victim_way_i,
    output      logic [`CACHE_TAG_W-1:0]    tag_o,
    output      logic [`CACHE_IDX_W-1:0]    set_o,
    output      cache_pkg::way_write_t      wr_o,
    output      logic                       touch_o,
    output      logic [`CACHE_WAY_W-1:0]    touch_way_o,
    output      cache_pkg::cache_rsp_t      rsp_o
);

    // Command classes
    logic                       is_load;
    logic                       is_store;
    logic                       is_fill;
    logic                       writes_data;
    // Way a missing block goes to and its current content
    logic [`CACHE_WAY_W-1:0]    fill_way;
    cache_pkg::cache_entry_t    old_entry;

    // ==============================
    // Address split
    // ==============================
    // Offset bits are dropped, blocks are stored whole
    assign tag_o = req_i.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign set_o = req_i.addr[`CACHE_OFFSET_W +: `CACHE_IDX_W];

    // ==============================
    // Decode
    // ==============================
    assign is_load  = (req_i.cmd == cache_pkg::REQ_LOAD);
    assign is_store = (req_i.cmd == cache_pkg::REQ_STORE);
    assign is_fill  = (req_i.cmd == cache_pkg::REQ_LOAD_MISS) ||
                      (req_i.cmd == cache_pkg::REQ_STORE_MISS);
    // Store data goes in on a store hit and on any store-miss write
    assign writes_data = is_store || (req_i.cmd == cache_pkg::REQ_STORE_MISS);

    // Empty way first, otherwise the LRU way
    assign fill_way  = empty_valid_i ? empty_way_i : victim_way_i;
    assign old_entry = set_entries_i[fill_way];

    // ==============================
    // Write, touch and response
    // ==============================
    always_comb begin
        wr_o        = '0;
        touch_o     = 1'b0;
        touch_way_o = '0;
        rsp_o       = '0;
        wr_o.set    = set_o;

        if ((is_load || is_store || is_fill) && hit_i) begin
            // Hit path, also taken by a fill whose block is already present
            rsp_o.hit      = 1'b1;
            rsp_o.data_out = set_entries_i[hit_way_i].data;
            touch_o        = 1'b1;
            touch_way_o    = hit_way_i;
            if (writes_data) begin
                wr_o.en          = 1'b1;
                wr_o.way         = hit_way_i;
                wr_o.entry.valid = 1'b1;
                wr_o.entry.dirty = 1'b1;
                wr_o.entry.tag   = tag_o;
                wr_o.entry.data  = req_i.data_in;
            end
        end else if (is_fill) begin
            // Place the supplied block
            wr_o.en          = 1'b1;
            wr_o.way         = fill_way;
            wr_o.entry.valid = 1'b1;
            // Load fills come in clean
            wr_o.entry.dirty = writes_data;
            wr_o.entry.tag   = tag_o;
            wr_o.entry.data  = req_i.data_in;
            touch_o          = 1'b1;
            touch_way_o      = fill_way;
            // Full set, the old block leaves
            if (!empty_valid_i) begin
                rsp_o.evict_valid = 1'b1;
                rsp_o.evict_dirty = old_entry.dirty;
                rsp_o.evict_addr  = {old_entry.tag, set_o, {`CACHE_OFFSET_W{1'b0}}};
                rsp_o.evict_data  = old_entry.data;
            end
        end
    end

    // Idle cycles leave both array and LRU state alone
    always_comb begin
        a_idle_quiet : assert final (
            (req_i.cmd != cache_pkg::REQ_NONE) || (!wr_o.en && !touch_o)
        ) else $error("write or touch issued without a command");
    end

endmodule

`default_nettype wire

// File: cache_mem_top.sv
/*
 * Cache storage top level
 * Connects request control, tag lookup, way array and LRU matrix.
 * One command per cycle, answered combinationally
 */

`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module cache_mem_top (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    input  wire cache_pkg::cache_req_t  req_i,
    output      cache_pkg::cache_rsp_t  rsp_o
);

    // ==============================
    // Internal nets
    // ==============================
    // Address fields
    logic [`CACHE_TAG_W-1:0]    tag;
    logic [`CACHE_IDX_W-1:0]    set;
    // Addressed set contents
    cache_pkg::cache_set_t      set_entries;
    // Lookup results
    logic                       hit;
    logic [`CACHE_WAY_W-1:0]    hit_way;
    logic                       empty_valid;
    logic [`CACHE_WAY_W-1:0]    empty_way;
    // LRU
    logic [`CACHE_WAY_W-1:0]    victim_way;
    logic                       touch;
    logic [`CACHE_WAY_W-1:0]    touch_way;
    // Array update
    cache_pkg::way_write_t      wr;

    // Decode and response forming
    cache_req_ctrl i_cache_req_ctrl (
        .req_i         (req_i),
        .set_entries_i (set_entries),
        .hit_i         (hit),
        .hit_way_i     (hit_way),
        .empty_valid_i (empty_valid),
        .empty_way_i   (empty_way),
        .victim_way_i  (victim_way),
        .tag_o         (tag),
        .set_o         (set),
        .wr_o          (wr),
        .touch_o       (touch),
        .touch_way_o   (touch_way),
        .rsp_o         (rsp_o)
    );

    // Tag compare and free-way search
    cache_way_lookup i_cache_way_lookup (
        .set_entries_i (set_entries),
        .tag_i         (tag),
        .hit_o         (hit),
        .hit_way_o     (hit_way),
        .empty_valid_o (empty_valid),
        .empty_way_o   (empty_way)
    );

    // Entry storage
    cache_way_array i_cache_way_array (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .rd_set_i      (set),
        .wr_i          (wr),
        .set_entries_o (set_entries)
    );

    // Replacement order
    cache_lru_matrix i_cache_lru_matrix (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .set_i        (set),
        .touch_i      (touch),
        .touch_way_i  (touch_way),
        .victim_way_o (victim_way)
    );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
/*
 * Testbench clock and reset
 * 8 ns clock, synchronous reset held for 4 rising edges
 */

`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    // Half period of 4 ns
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        rst_o = 1'b1;
        repeat (4) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb_cache_mem.sv
/*
 * Cache storage testbench
 * Directed and random commands against a reference model that keeps
 * its own way contents and LRU order, compared every cycle
 */

`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module tb_cache_mem;

    // ==============================
    // Run length
    // ==============================
    localparam int N_RANDOM    = 400;
    // Upper bound on directed commands
    localparam int N_DIRECTED  = 64;
    localparam int CLK_NS      = 8;
    localparam int RESET_NS    = 5 * CLK_NS;
    localparam int WATCHDOG_NS = 2 * (N_DIRECTED + N_RANDOM) * CLK_NS + RESET_NS;

    logic                   clk;
    logic                   rst;
    cache_pkg::cache_req_t  req;
    cache_pkg::cache_rsp_t  rsp;
    // Response sampled for the latest command
    cache_pkg::cache_rsp_t  last_rsp;
    cache_pkg::cache_rsp_t  exp_rsp;

    int n_checks;
    int n_errors;
    int n_tests;
    int n_failed;
    int n_cmds;

    // Reference model state
    // Order index 0 holds the oldest way
    logic                       m_valid [`CACHE_SETS][`CACHE_WAYS];
    logic                       m_dirty [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_TAG_W-1:0]    m_tag   [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_DATA_W-1:0]   m_data  [`CACHE_SETS][`CACHE_WAYS];
    int                         m_order [`CACHE_SETS][`CACHE_WAYS];

    tb_clk_gen i_tb_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    cache_mem_top i_cache_mem_top (
        .clk_i (clk),
        .rst_i (rst),
        .req_i (req),
        .rsp_o (rsp)
    );

    // ==============================
    // Reference model
    // ==============================
    function automatic logic [31:0] make_addr(input logic [25:0] tag, input logic [2:0] set,
                                              input logic [2:0] off);
        return {tag, set, off};
    endfunction

    // Block contents tied to the whole address
    function automatic logic [63:0] block_data(input logic [31:0] addr, input logic [7:0] salt);
        return {addr, addr ^ {4{salt}}};
    endfunction

    function automatic int model_hit_way(input int s, input logic [25:0] tag);
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == tag) return w;
        end
        return -1;
    endfunction

    // Lowest free way, else the oldest one
    function automatic int model_fill_way(input int s);
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!m_valid[s][w]) return w;
        end
        return m_order[s][0];
    endfunction

    // Used way moves to the newest position
    function automatic void model_touch(input int s, input int w);
        int pos;
        pos = 0;
        for (int k = 0; k < `CACHE_WAYS; k++) begin
            if (m_order[s][k] == w) pos = k;
        end
        for (int k = pos; k < `CACHE_WAYS - 1; k++) begin
            m_order[s][k] = m_order[s][k + 1];
        end
        m_order[s][`CACHE_WAYS - 1] = w;
    endfunction

    function automatic cache_pkg::cache_rsp_t expect_rsp(input cache_pkg::cache_req_t r);
        cache_pkg::cache_rsp_t e;
        int s;
        int hw;
        int fw;
        e  = '0;
        s  = int'(r.addr[5:3]);
        hw = model_hit_way(s, r.addr[31:6]);
        if (r.cmd == cache_pkg::REQ_NONE) return e;
        if (hw >= 0) begin
            e.hit      = 1'b1;
            e.data_out = m_data[s][hw];
        end else if (r.cmd == cache_pkg::REQ_LOAD_MISS || r.cmd == cache_pkg::REQ_STORE_MISS) begin
            fw = model_fill_way(s);
            // Only a full set gives up a block
            if (m_valid[s][fw]) begin
                e.evict_valid = 1'b1;
                e.evict_dirty = m_dirty[s][fw];
                e.evict_addr  = make_addr(m_tag[s][fw], r.addr[5:3], 3'd0);
                e.evict_data  = m_data[s][fw];
            end
        end
        return e;
    endfunction

    function automatic void model_apply(input cache_pkg::cache_req_t r);
        int s;
        int w;
        logic is_fill;
        logic is_st;
        s       = int'(r.addr[5:3]);
        w       = model_hit_way(s, r.addr[31:6]);
        is_fill = (r.cmd == cache_pkg::REQ_LOAD_MISS) || (r.cmd == cache_pkg::REQ_STORE_MISS);
        is_st   = (r.cmd == cache_pkg::REQ_STORE) || (r.cmd == cache_pkg::REQ_STORE_MISS);
        if (r.cmd == cache_pkg::REQ_NONE || (w < 0 && !is_fill)) return;
        if (w < 0) begin
            w = model_fill_way(s);
            m_valid[s][w] = 1'b1;
            m_dirty[s][w] = 1'b0;
            m_tag[s][w]   = r.addr[31:6];
            m_data[s][w]  = r.data_in;
        end
        // Stores write on a hit and on a placement
        if (is_st) begin
            m_dirty[s][w] = 1'b1;
            m_data[s][w]  = r.data_in;
        end
        model_touch(s, w);
    endfunction

    // ==============================
    // Checks
    // ==============================
    task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        assert (got === exp) else begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            n_errors++;
        end
    endtask

    // Compare just before the rising edge, then advance the model
    always begin
        @(negedge clk);
        #3;
        if (!rst) begin
            exp_rsp  = expect_rsp(req);
            last_rsp = rsp;
            check_field("rsp_o.hit", last_rsp.hit, exp_rsp.hit);
            check_field("rsp_o.data_out", last_rsp.data_out, exp_rsp.data_out);
            check_field("rsp_o.evict_valid", last_rsp.evict_valid, exp_rsp.evict_valid);
            check_field("rsp_o.evict_dirty", last_rsp.evict_dirty, exp_rsp.evict_dirty);
            check_field("rsp_o.evict_addr", last_rsp.evict_addr, exp_rsp.evict_addr);
            check_field("rsp_o.evict_data", last_rsp.evict_data, exp_rsp.evict_data);
            model_apply(req);
        end
    end

    task automatic expect_hit(input logic hit, input logic [63:0] data);
        check_field("rsp_o.hit", last_rsp.hit, hit);
        check_field("rsp_o.data_out", last_rsp.data_out, data);
    endtask

    task automatic expect_evict(input logic valid, input logic dirty, input logic [31:0] addr,
                                input logic [63:0] data);
        check_field("rsp_o.evict_valid", last_rsp.evict_valid, valid);
        check_field("rsp_o.evict_dirty", last_rsp.evict_dirty, dirty);
        check_field("rsp_o.evict_addr", last_rsp.evict_addr, addr);
        check_field("rsp_o.evict_data", last_rsp.evict_data, data);
    endtask

    // ==============================
    // Stimulus
    // ==============================
    // One command per cycle, held until the next falling edge
    task automatic issue(input cache_pkg::req_cmd_e cmd, input logic [31:0] addr,
                         input logic [63:0] data);
        @(negedge clk);
        req.cmd     = cmd;
        req.addr    = addr;
        req.data_in = data;
        @(posedge clk);
        n_cmds++;
    endtask

    task automatic fill(input logic [25:0] tag, input logic [2:0] set, input logic [7:0] salt);
        issue(cache_pkg::REQ_LOAD_MISS, make_addr(tag, set, 3'd0),
              block_data(make_addr(tag, set, 3'd0), salt));
    endtask

    task automatic finish_test(input string name, input int errs_before);
        n_tests++;
        if (n_errors != errs_before) n_failed++;
        $display("test %-16s %s, %0d errors", name,
                 (n_errors == errs_before) ? "PASS" : "FAIL", n_errors - errs_before);
    endtask

    task automatic reset_loads();
        for (int k = 0; k < 8; k++) begin
            issue(cache_pkg::REQ_LOAD, make_addr(26'($urandom), 3'(k), 3'($urandom)), '0);
            check_field("rsp_o (any bit)", 64'(|last_rsp), '0);
        end
    endtask

    task automatic fill_order();
        logic [31:0] a;
        for (int k = 0; k < 4; k++) begin
            fill(26'(10 + k), 3'd2, 8'h20);
            expect_evict(1'b0, 1'b0, '0, '0);
        end
        for (int k = 0; k < 4; k++) begin
            a = make_addr(26'(10 + k), 3'd2, 3'(k));
            issue(cache_pkg::REQ_LOAD, a, '0);
            expect_hit(1'b1, block_data(make_addr(26'(10 + k), 3'd2, 3'd0), 8'h20));
        end
    endtask

    task automatic dirty_tracking();
        int          vtag [4] = '{20, 22, 23, 21};
        logic [63:0] new_data;
        logic [31:0] va;
        new_data = 64'hd1d1_0000_cafe_0021;
        for (int k = 0; k < 4; k++) fill(26'(20 + k), 3'd5, 8'h30);
        issue(cache_pkg::REQ_STORE, make_addr(26'd21, 3'd5, 3'd4), new_data);
        expect_hit(1'b1, block_data(make_addr(26'd21, 3'd5, 3'd0), 8'h30));
        issue(cache_pkg::REQ_LOAD, make_addr(26'd21, 3'd5, 3'd0), '0);
        expect_hit(1'b1, new_data);
        // Clean blocks go first, the stored one last
        for (int k = 0; k < 4; k++) begin
            va = make_addr(26'(vtag[k]), 3'd5, 3'd0);
            fill(26'(24 + k), 3'd5, 8'h30);
            expect_evict(1'b1, k == 3, va, (k == 3) ? new_data : block_data(va, 8'h30));
        end
    endtask

    task automatic lru_eviction();
        logic [31:0] a;
        for (int k = 0; k < 4; k++) fill(26'(30 + k), 3'd7, 8'h40);
        issue(cache_pkg::REQ_LOAD, make_addr(26'd30, 3'd7, 3'd0), '0);
        issue(cache_pkg::REQ_LOAD, make_addr(26'd32, 3'd7, 3'd0), '0);
        // Hits on 30 and 32 leave 31 the oldest
        a = make_addr(26'd31, 3'd7, 3'd0);
        fill(26'd34, 3'd7, 8'h40);
        expect_evict(1'b1, 1'b0, a, block_data(a, 8'h40));
        issue(cache_pkg::REQ_LOAD, make_addr(26'd33, 3'd7, 3'd0), '0);
        a = make_addr(26'd30, 3'd7, 3'd0);
        fill(26'd35, 3'd7, 8'h40);
        expect_evict(1'b1, 1'b0, a, block_data(a, 8'h40));
    endtask

    task automatic fill_on_hit();
        logic [31:0] a;
        logic [63:0] st_data;
        a       = make_addr(26'd40, 3'd1, 3'd0);
        st_data = 64'h5700_5700_0000_0040;
        fill(26'd40, 3'd1, 8'h50);
        issue(cache_pkg::REQ_LOAD_MISS, a, 64'hbad0_bad0_bad0_bad0);
        expect_hit(1'b1, block_data(a, 8'h50));
        expect_evict(1'b0, 1'b0, '0, '0);
        issue(cache_pkg::REQ_STORE_MISS, a, st_data);
        expect_hit(1'b1, block_data(a, 8'h50));
        issue(cache_pkg::REQ_LOAD, a, '0);
        expect_hit(1'b1, st_data);
        // Three free ways must remain
        for (int k = 1; k < 4; k++) begin
            fill(26'(40 + k), 3'd1, 8'h50);
            expect_evict(1'b0, 1'b0, '0, '0);
        end
        fill(26'd44, 3'd1, 8'h50);
        expect_evict(1'b1, 1'b1, a, st_data);
    endtask

    // Six tags over two sets keeps evictions frequent
    task automatic random_stream();
        logic [2:0]  c;
        logic [31:0] a;
        for (int k = 0; k < N_RANDOM; k++) begin
            c = 3'($urandom_range(4, 0));
            a = make_addr(26'($urandom_range(5, 0)), 3'($urandom_range(1, 0)), 3'($urandom));
            issue(cache_pkg::req_cmd_e'(c), a, {$urandom, $urandom});
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int e0;
        void'($urandom(32'h5a99));
        req      = '0;
        last_rsp = '0;
        n_checks = 0;
        n_errors = 0;
        n_tests  = 0;
        n_failed = 0;
        n_cmds   = 0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
                m_data[s][w]  = '0;
                m_order[s][w] = w;
            end
        end
        wait (rst == 1'b0);
        e0 = n_errors;
        reset_loads();
        finish_test("reset_loads", e0);
        e0 = n_errors;
        fill_order();
        finish_test("fill_order", e0);
        e0 = n_errors;
        dirty_tracking();
        finish_test("dirty_tracking", e0);
        e0 = n_errors;
        lru_eviction();
        finish_test("lru_eviction", e0);
        e0 = n_errors;
        fill_on_hit();
        finish_test("fill_on_hit", e0);
        e0 = n_errors;
        random_stream();
        finish_test("random_stream", e0);
        $display("tests %0d, failed %0d, commands %0d, checks %0d, errors %0d",
                 n_tests, n_failed, n_cmds, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Twice the command budget plus reset
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with %0d commands issued", WATCHDOG_NS, n_cmds);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
cache_pkg.sv
cache_way_array.sv
cache_way_lookup.sv
cache_lru_matrix.sv
cache_req_ctrl.sv
cache_mem_top.sv
tb_clk_gen.sv
tb_cache_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the cache storage testbench with Verilator and run it.
# Exit status is nonzero when the build, the run or any check fails.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cache_mem -f src.f -o sim_cache_mem > build.log 2>&1 \
    && ./obj_dir/sim_cache_mem > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0
